//--- Makefile
# Verilator flow for the SoC control block testbench
TOP := soc_ctrl_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f -o $(TOP)

run: compile
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
	  echo "Run failed, see $(LOG)"; exit 1; \
	elif ! grep -q "Simulation PASSED" $(LOG); then \
	  echo "Run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- build.f
design/soc_ctrl_pkg.sv
design/addr_decode.sv
design/clint_exec.sv
design/resp_fifo.sv
design/dbg_req_gate.sv
design/soc_ctrl_top.sv
verification/soc_ctrl_checker.sv
verification/soc_ctrl_tb.sv

//--- design/addr_decode.sv
// One register stage; a request outside the ROM and CLINT windows is tagged TGT_NONE, never dropped
`timescale 1ns/1ps

module addr_decode (
  input  logic                   clk_i,
  input  logic                   ndmreset_n,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  soc_ctrl_pkg::bus_req_t req_i,
  output logic                   op_valid_o,
  input  logic                   op_ready_i,
  output soc_ctrl_pkg::dec_op_t  op_o
);

  logic                  rom_hit;
  logic                  clint_hit;
  logic                  req_fire;
  logic                  op_valid_q;
  soc_ctrl_pkg::dec_op_t op_d;
  soc_ctrl_pkg::dec_op_t op_q;

  // ----------------------------------------------------------
  // Rule match, base <= addr < base + length
  // ----------------------------------------------------------
  assign rom_hit   = (req_i.addr >= soc_ctrl_pkg::ROM_BASE) &&
                     (req_i.addr <  soc_ctrl_pkg::ROM_BASE + soc_ctrl_pkg::ROM_LENGTH);
  assign clint_hit = (req_i.addr >= soc_ctrl_pkg::CLINT_BASE) &&
                     (req_i.addr <  soc_ctrl_pkg::CLINT_BASE + soc_ctrl_pkg::CLINT_LENGTH);

  always_comb begin
    op_d.we    = req_i.we;
    op_d.wdata = req_i.wdata;
    if (rom_hit) begin
      op_d.tgt    = soc_ctrl_pkg::TGT_ROM;
      op_d.offset = req_i.addr - soc_ctrl_pkg::ROM_BASE;
    end else if (clint_hit) begin
      op_d.tgt    = soc_ctrl_pkg::TGT_CLINT;
      op_d.offset = req_i.addr - soc_ctrl_pkg::CLINT_BASE;
    end else begin
      // Unmapped, keep full address for visibility
      op_d.tgt    = soc_ctrl_pkg::TGT_NONE;
      op_d.offset = req_i.addr;
    end
  end

  // Stage frees up when empty or drained this cycle
  assign req_ready_o = !op_valid_q || op_ready_i;
  assign req_fire    = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      op_valid_q <= 1'b0;
    end else if (req_ready_o) begin
      op_valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      op_q <= op_d;
    end
  end

  assign op_valid_o = op_valid_q;
  assign op_o       = op_q;

endmodule

//--- design/clint_exec.sv
// Single-hart CLINT plus ROM reads; rtc_i must be synchronous to clk_i and slower than clk_i / 2
`timescale 1ns/1ps

module clint_exec (
  input  logic                   clk_i,
  input  logic                   ndmreset_n,
  input  logic                   rtc_i,
  input  logic                   op_valid_i,
  output logic                   op_ready_o,
  input  soc_ctrl_pkg::dec_op_t  op_i,
  output logic                   res_valid_o,
  input  logic                   res_ready_i,
  output soc_ctrl_pkg::bus_rsp_t res_o,
  output logic                   timer_irq_o,
  output logic                   ipi_o
);

  logic                   msip_q;
  soc_ctrl_pkg::data_t    mtimecmp_q;
  soc_ctrl_pkg::data_t    mtime_q;
  logic                   rtc_q;
  logic                   rtc_div_q;
  logic                   rtc_rise;
  logic                   rtc_tick;
  logic                   is_clint;
  logic                   is_msip;
  logic                   is_mtimecmp;
  logic                   is_mtime;
  logic                   op_fire;
  logic                   res_valid_q;
  soc_ctrl_pkg::bus_rsp_t res_d;
  soc_ctrl_pkg::bus_rsp_t res_q;

  // ----------------------------------------------------------
  // RTC divide by two
  // ----------------------------------------------------------
  assign rtc_rise = rtc_i && !rtc_q;
  // Every second rising edge
  assign rtc_tick = rtc_rise && rtc_div_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_q     <= 1'b0;
      rtc_div_q <= 1'b0;
    end else begin
      rtc_q <= rtc_i;
      if (rtc_rise) begin
        rtc_div_q <= !rtc_div_q;
      end
    end
  end

  // ----------------------------------------------------------
  // Register decode and execute
  // ----------------------------------------------------------
  assign is_clint    = (op_i.tgt == soc_ctrl_pkg::TGT_CLINT);
  assign is_msip     = is_clint && (op_i.offset == soc_ctrl_pkg::MSIP_OFFSET);
  assign is_mtimecmp = is_clint && (op_i.offset == soc_ctrl_pkg::MTIMECMP_OFFSET);
  assign is_mtime    = is_clint && (op_i.offset == soc_ctrl_pkg::MTIME_OFFSET);

  assign op_ready_o = !res_valid_q || res_ready_i;
  assign op_fire    = op_valid_i && op_ready_o;

  always_comb begin
    res_d.rdata = '0;
    res_d.err   = 1'b0;
    case (op_i.tgt)
      soc_ctrl_pkg::TGT_ROM: begin
        if (op_i.we) begin
          res_d.err = 1'b1;
        end else begin
          res_d.rdata = soc_ctrl_pkg::BOOT_ROM[op_i.offset[5:3]];
        end
      end
      soc_ctrl_pkg::TGT_CLINT: begin
        // Reads see the value before this op; unknown offsets read zero
        if (!op_i.we) begin
          if (is_msip) begin
            res_d.rdata = {63'd0, msip_q};
          end else if (is_mtimecmp) begin
            res_d.rdata = mtimecmp_q;
          end else if (is_mtime) begin
            res_d.rdata = mtime_q;
          end
        end
      end
      default: res_d.err = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      msip_q     <= 1'b0;
      mtimecmp_q <= '1;
      mtime_q    <= '0;
    end else begin
      if (op_fire && op_i.we && is_msip) begin
        msip_q <= op_i.wdata[0];
      end
      if (op_fire && op_i.we && is_mtimecmp) begin
        mtimecmp_q <= op_i.wdata;
      end
      // A write wins over the tick in the same cycle
      if (op_fire && op_i.we && is_mtime) begin
        mtime_q <= op_i.wdata;
      end else if (rtc_tick) begin
        mtime_q <= mtime_q + 64'd1;
      end
    end
  end

  // ----------------------------------------------------------
  // Response stage
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      res_valid_q <= 1'b0;
    end else if (op_ready_o) begin
      res_valid_q <= op_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (op_fire) begin
      res_q <= res_d;
    end
  end

  assign res_valid_o = res_valid_q;
  assign res_o       = res_q;
  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o       = msip_q;

endmodule

//--- design/dbg_req_gate.sv
// Debug requests are masked for DBG_HOLD_CYCLES clocks after reset, then pass through combinationally
`timescale 1ns/1ps

module dbg_req_gate (
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic debug_req_i,
  output logic debug_req_o
);

  logic [31:0] hold_cnt_q;
  logic        hold_active;

  // Gives boot code time to set up before a halt
  assign hold_active = (hold_cnt_q != 32'd0);

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      hold_cnt_q <= soc_ctrl_pkg::DBG_HOLD_CYCLES;
    end else if (hold_active) begin
      hold_cnt_q <= hold_cnt_q - 32'd1;
    end
  end

  assign debug_req_o = hold_active ? 1'b0 : debug_req_i;

endmodule

//--- design/resp_fifo.sv
// Two entries, no fall-through path; an entry written at one edge is visible from the next
`timescale 1ns/1ps

module resp_fifo (
  input  logic                   clk_i,
  input  logic                   ndmreset_n,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  soc_ctrl_pkg::bus_rsp_t in_i,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output soc_ctrl_pkg::bus_rsp_t out_o
);

  soc_ctrl_pkg::bus_rsp_t mem_q [2];
  logic                   wr_ptr_q;
  logic                   rd_ptr_q;
  logic [1:0]             count_q;
  logic                   push;
  logic                   pop;

  assign in_ready_o  = (count_q != 2'd2);
  assign out_valid_o = (count_q != 2'd0);
  assign push        = in_valid_i && in_ready_o;
  assign pop         = out_valid_o && out_ready_i;

  // ----------------------------------------------------------
  // Pointers and fill level
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= !rd_ptr_q;
      end
      if (push && !pop) begin
        count_q <= count_q + 2'd1;
      end else if (pop && !push) begin
        count_q <= count_q - 2'd1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_i;
    end
  end

  assign out_o = mem_q[rd_ptr_q];

endmodule

//--- design/soc_ctrl_pkg.sv
// Single hart only; widths, address map and boot ROM image are fixed here and need a rebuild to change
package soc_ctrl_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  typedef logic [31:0] addr_t;
  typedef logic [63:0] data_t;
  typedef logic [1:0]  tgt_sel_t;

  // Decode target codes
  localparam tgt_sel_t TGT_NONE  = 2'd0;
  localparam tgt_sel_t TGT_ROM   = 2'd1;
  localparam tgt_sel_t TGT_CLINT = 2'd2;

  // ----------------------------------------------------------
  // Address map
  // ----------------------------------------------------------
  localparam addr_t ROM_BASE     = 32'h0001_0000;
  localparam addr_t ROM_LENGTH   = 32'h0000_0040;
  localparam addr_t CLINT_BASE   = 32'h0200_0000;
  localparam addr_t CLINT_LENGTH = 32'h0000_C000;

  // CLINT register offsets, hart 0
  localparam addr_t MSIP_OFFSET     = 32'h0000_0000;
  localparam addr_t MTIMECMP_OFFSET = 32'h0000_4000;
  localparam addr_t MTIME_OFFSET    = 32'h0000_BFF8;

  // Boot image, two instructions per word
  localparam int unsigned ROM_WORDS = 8;
  localparam data_t BOOT_ROM [ROM_WORDS] = '{
    64'h0202_8293_0000_0297,
    64'h0010_0513_f140_25f3,
    64'h0005_8593_0000_0617,
    64'h1050_0073_0282_8067,
    64'h0000_0013_ffdf_f06f,
    64'h0000_0000_0000_0000,
    64'h8000_0000_0000_0000,
    64'h0000_0001_0001_0000
  };

  // Cycles after reset before a debug request can reach the hart
  localparam logic [31:0] DBG_HOLD_CYCLES = 32'd500;

  // ----------------------------------------------------------
  // Bus payloads
  // ----------------------------------------------------------
  typedef struct packed {
    addr_t addr;
    logic  we;
    data_t wdata;
  } bus_req_t;

  typedef struct packed {
    tgt_sel_t tgt;
    addr_t    offset;
    logic     we;
    data_t    wdata;
  } dec_op_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_rsp_t;

endpackage

//--- design/soc_ctrl_top.sv
// Single-hart control block; rtc_i must be synchronous to clk_i, responses return in request order
`timescale 1ns/1ps

module soc_ctrl_top (
  input  logic                   clk_i,
  input  logic                   ndmreset_n,
  input  logic                   rtc_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  soc_ctrl_pkg::bus_req_t req_i,
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output soc_ctrl_pkg::bus_rsp_t rsp_o,
  input  logic                   debug_req_i,
  output logic                   debug_req_o,
  output logic                   timer_irq_o,
  output logic                   ipi_o
);

  logic                   op_valid;
  logic                   op_ready;
  soc_ctrl_pkg::dec_op_t  op;
  logic                   res_valid;
  logic                   res_ready;
  soc_ctrl_pkg::bus_rsp_t res;

  // ----------------------------------------------------------
  // Request path
  // ----------------------------------------------------------
  addr_decode i_addr_decode (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .req_valid_i ( req_valid_i ),
    .req_ready_o ( req_ready_o ),
    .req_i       ( req_i       ),
    .op_valid_o  ( op_valid    ),
    .op_ready_i  ( op_ready    ),
    .op_o        ( op          )
  );

  clint_exec i_clint_exec (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .op_valid_i  ( op_valid    ),
    .op_ready_o  ( op_ready    ),
    .op_i        ( op          ),
    .res_valid_o ( res_valid   ),
    .res_ready_i ( res_ready   ),
    .res_o       ( res         ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  resp_fifo i_resp_fifo (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .in_valid_i  ( res_valid   ),
    .in_ready_o  ( res_ready   ),
    .in_i        ( res         ),
    .out_valid_o ( rsp_valid_o ),
    .out_ready_i ( rsp_ready_i ),
    .out_o       ( rsp_o       )
  );

  // Debug hold-off
  dbg_req_gate i_dbg_req_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

//--- verification/soc_ctrl_checker.sv
// Bound into soc_ctrl_top; all properties are disabled while ndmreset_n is low
`timescale 1ns/1ps

module soc_ctrl_checker (
  input logic                   clk_i,
  input logic                   ndmreset_n,
  input logic                   rsp_valid_i,
  input logic                   rsp_ready_i,
  input soc_ctrl_pkg::bus_rsp_t rsp_i,
  input logic                   dbg_in_i,
  input logic                   dbg_out_i,
  input logic                   op_valid_i,
  input logic                   op_ready_i,
  input logic                   ipi_i
);

  // ----------------------------------------------------------
  // Response channel holds while stalled
  // ----------------------------------------------------------
  rsp_hold: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (rsp_valid_i && !rsp_ready_i) |=> (rsp_valid_i && $stable(rsp_i)))
    else $error("rsp_o changed while stalled");

  // Gate never invents a request
  dbg_no_spurious: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    !dbg_in_i |-> !dbg_out_i)
    else $error("debug_req_o high without debug_req_i");

  // msip only moves on an accepted op
  ipi_on_op: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    !(op_valid_i && op_ready_i) |=> $stable(ipi_i))
    else $error("ipi_o changed without an accepted op");

endmodule

bind soc_ctrl_top soc_ctrl_checker i_soc_ctrl_checker (
  .clk_i       ( clk_i       ),
  .ndmreset_n  ( ndmreset_n  ),
  .rsp_valid_i ( rsp_valid_o ),
  .rsp_ready_i ( rsp_ready_i ),
  .rsp_i       ( rsp_o       ),
  .dbg_in_i    ( debug_req_i ),
  .dbg_out_i   ( debug_req_o ),
  .op_valid_i  ( op_valid    ),
  .op_ready_i  ( op_ready    ),
  .ipi_i       ( ipi_o       )
);

//--- verification/soc_ctrl_tb.sv
// Random rsp_ready_i with a fixed seed; rtc_i is toggled only inside the timer step of the table
`timescale 1ns/1ps

module soc_ctrl_tb;

  typedef enum logic [1:0] {PRE_NONE, PRE_IPI, PRE_RTC} pre_t;

  // One table row, pre runs before the request is issued
  typedef struct packed {
    soc_ctrl_pkg::addr_t addr;
    logic                we;
    soc_ctrl_pkg::data_t wdata;
    soc_ctrl_pkg::data_t exp_rdata;
    logic                exp_err;
    pre_t                pre;
  } stim_t;

  logic                   clk_i;
  logic                   ndmreset_n;
  logic                   rtc_i;
  logic                   req_valid_i;
  logic                   req_ready_o;
  soc_ctrl_pkg::bus_req_t req_i;
  logic                   rsp_valid_o;
  logic                   rsp_ready_i;
  soc_ctrl_pkg::bus_rsp_t rsp_o;
  logic                   debug_req_i;
  logic                   debug_req_o;
  logic                   timer_irq_o;
  logic                   ipi_o;

  stim_t       table_q [$];
  int unsigned issued = 0;
  int unsigned rsp_count = 0;
  logic        exp_ipi = 1'b0;
  logic        dbg_done = 1'b0;
  integer      seed = 32'h3214_e1de;
  int unsigned rtc_periods = 8;

  soc_ctrl_top i_soc_ctrl_top (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .req_valid_i ( req_valid_i ),
    .req_ready_o ( req_ready_o ),
    .req_i       ( req_i       ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_ready_i ( rsp_ready_i ),
    .rsp_o       ( rsp_o       ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------
  // Reporting
  // ----------------------------------------------------------
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_equal(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, actual, expected));
    end
  endtask

  // ----------------------------------------------------------
  // Stimulus table
  // ----------------------------------------------------------
  task automatic add_entry(input soc_ctrl_pkg::addr_t addr, input logic we,
                           input soc_ctrl_pkg::data_t wdata,
                           input soc_ctrl_pkg::data_t rdata, input logic err,
                           input pre_t pre);
    stim_t e;
    e.addr      = addr;
    e.we        = we;
    e.wdata     = wdata;
    e.exp_rdata = rdata;
    e.exp_err   = err;
    e.pre       = pre;
    table_q.push_back(e);
  endtask

  task automatic build_table();
    int                  i;
    soc_ctrl_pkg::addr_t cl;
    cl = soc_ctrl_pkg::CLINT_BASE;
    for (i = 0; i < soc_ctrl_pkg::ROM_WORDS; i++) begin
      add_entry(soc_ctrl_pkg::ROM_BASE + 32'(i * 8), 1'b0, '0,
                soc_ctrl_pkg::BOOT_ROM[i], 1'b0, PRE_NONE);
    end
    add_entry(cl + soc_ctrl_pkg::MSIP_OFFSET, 1'b1, 64'h1, '0, 1'b0, PRE_NONE);
    add_entry(cl + soc_ctrl_pkg::MSIP_OFFSET, 1'b0, '0, 64'h1, 1'b0, PRE_IPI);
    add_entry(cl + soc_ctrl_pkg::MTIMECMP_OFFSET, 1'b1, 64'h0123_4567_89ab_cdef, '0, 1'b0,
              PRE_NONE);
    add_entry(cl + soc_ctrl_pkg::MTIMECMP_OFFSET, 1'b0, '0, 64'h0123_4567_89ab_cdef, 1'b0,
              PRE_NONE);
    // Only bit 0 of msip is stored
    add_entry(cl + soc_ctrl_pkg::MSIP_OFFSET, 1'b1, 64'hffff_ffff_ffff_fffe, '0, 1'b0,
              PRE_NONE);
    add_entry(cl + soc_ctrl_pkg::MSIP_OFFSET, 1'b0, '0, 64'h0, 1'b0, PRE_IPI);
    // ROM write, unmapped and just past both regions
    add_entry(soc_ctrl_pkg::ROM_BASE + 32'd8, 1'b1, 64'hdead_beef, '0, 1'b1, PRE_NONE);
    add_entry(32'h0000_1000, 1'b0, '0, '0, 1'b1, PRE_NONE);
    add_entry(soc_ctrl_pkg::ROM_BASE + soc_ctrl_pkg::ROM_LENGTH, 1'b0, '0, '0, 1'b1, PRE_NONE);
    add_entry(cl + soc_ctrl_pkg::CLINT_LENGTH, 1'b1, 64'h5, '0, 1'b1, PRE_NONE);
    add_entry(cl + 32'h0000_0100, 1'b0, '0, '0, 1'b0, PRE_NONE);
    // Timer, one mtime tick per two rtc periods
    add_entry(cl + soc_ctrl_pkg::MTIME_OFFSET, 1'b1, '0, '0, 1'b0, PRE_NONE);
    add_entry(cl + soc_ctrl_pkg::MTIMECMP_OFFSET, 1'b1, 64'd3, '0, 1'b0, PRE_NONE);
    add_entry(cl + soc_ctrl_pkg::MTIME_OFFSET, 1'b0, '0, 64'(rtc_periods / 2), 1'b0, PRE_RTC);
    // Back-to-back burst for ordering
    for (i = soc_ctrl_pkg::ROM_WORDS - 1; i >= 0; i--) begin
      add_entry(soc_ctrl_pkg::ROM_BASE + 32'(i * 8), 1'b0, '0,
                soc_ctrl_pkg::BOOT_ROM[i], 1'b0, PRE_NONE);
    end
  endtask

  // ----------------------------------------------------------
  // Request driver, called on a falling edge
  // ----------------------------------------------------------
  task automatic run_pre_step(input pre_t pre);
    int unsigned n;
    while (rsp_count != issued) @(negedge clk_i);
    if (pre == PRE_IPI) begin
      check_equal("ipi_o", 64'(ipi_o), 64'(exp_ipi));
    end else begin
      check_equal("timer_irq_o", 64'(timer_irq_o), 64'd0);
      for (n = 0; n < rtc_periods; n++) begin
        rtc_i = 1'b1;
        repeat (2) @(negedge clk_i);
        rtc_i = 1'b0;
        repeat (2) @(negedge clk_i);
      end
      check_equal("timer_irq_o", 64'(timer_irq_o), 64'd1);
    end
  endtask

  task automatic issue(input stim_t e);
    req_valid_i = 1'b1;
    req_i.addr  = e.addr;
    req_i.we    = e.we;
    req_i.wdata = e.wdata;
    // Ready depends on stage state only, settled since the last rising edge
    while (!req_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    req_valid_i = 1'b0;
    issued++;
    if (e.we && (e.addr == soc_ctrl_pkg::CLINT_BASE + soc_ctrl_pkg::MSIP_OFFSET)) begin
      exp_ipi = e.wdata[0];
    end
  endtask

  initial begin : main_seq
    int unsigned idx;
    ndmreset_n  = 1'b0;
    rtc_i       = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    debug_req_i = 1'b0;
    build_table();
    repeat (10) @(negedge clk_i);
    ndmreset_n  = 1'b1;
    debug_req_i = 1'b1;
    check_equal("req_ready_o", 64'(req_ready_o), 64'd1);
    check_equal("rsp_valid_o", 64'(rsp_valid_o), 64'd0);
    check_equal("timer_irq_o", 64'(timer_irq_o), 64'd0);
    check_equal("ipi_o", 64'(ipi_o), 64'd0);
    for (idx = 0; idx < table_q.size(); idx++) begin
      if (table_q[idx].pre != PRE_NONE) begin
        run_pre_step(table_q[idx].pre);
      end
      issue(table_q[idx]);
    end
    while (rsp_count != table_q.size() || !dbg_done) @(negedge clk_i);
    // Extra cycles expose a duplicate response
    repeat (20) @(negedge clk_i);
    $display("Simulation PASSED");
    $finish;
  end

  // ----------------------------------------------------------
  // Response collector with random back-pressure
  // ----------------------------------------------------------
  initial begin : collect
    stim_t e;
    rsp_ready_i = 1'b0;
    forever begin
      @(negedge clk_i);
      rsp_ready_i = (($random(seed) & 32'd1) != 32'd0);
      if (ndmreset_n && rsp_valid_o && rsp_ready_i) begin
        if (rsp_count >= table_q.size()) begin
          fail_run("A response arrived with no request outstanding");
        end
        e = table_q[rsp_count];
        check_equal($sformatf("rsp_o.rdata[%0d]", rsp_count), rsp_o.rdata, e.exp_rdata);
        check_equal($sformatf("rsp_o.err[%0d]", rsp_count), 64'(rsp_o.err), 64'(e.exp_err));
        rsp_count++;
      end
    end
  end

  // Debug hold-off window around DBG_HOLD_CYCLES
  initial begin : dbg_hold_check
    int unsigned cyc;
    @(posedge ndmreset_n);
    for (cyc = 1; cyc <= soc_ctrl_pkg::DBG_HOLD_CYCLES + 11; cyc++) begin
      @(negedge clk_i);
      if (cyc < soc_ctrl_pkg::DBG_HOLD_CYCLES - 10) begin
        check_equal("debug_req_o", 64'(debug_req_o), 64'd0);
      end else if (cyc > soc_ctrl_pkg::DBG_HOLD_CYCLES + 10) begin
        check_equal("debug_req_o", 64'(debug_req_o), 64'd1);
      end
    end
    // Past the hold-off the gate follows a dropped request too
    debug_req_i = 1'b0;
    @(negedge clk_i);
    check_equal("debug_req_o", 64'(debug_req_o), 64'd0);
    dbg_done = 1'b1;
  end

  initial begin : watchdog
    int unsigned limit;
    @(posedge ndmreset_n);
    limit = table_q.size() * 40 + rtc_periods * 4 + soc_ctrl_pkg::DBG_HOLD_CYCLES + 100;
    repeat (limit) @(posedge clk_i);
    fail_run($sformatf("Timeout: run did not finish within %0d cycles", limit));
  end

endmodule
